//--- common/rvCore_defines.svh
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// default instruction buffer depth
`define BUF_DEPTH 2

// architectural registers, x0 included
`define NUM_REGS 32

`endif

//--- common/rvPkg.sv
`default_nettype none

`include "rvCore_defines.svh"

package rvPkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcodeE;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } aluOpE;

  typedef struct packed {
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
    logic             pwrite;
    logic             psel;
    logic             penable;
  } apbReqT;

  typedef struct packed {
    logic [`XLEN-1:0] prdata;
    logic             pready;
  } apbRspT;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
  } fetchPacketT;

  typedef struct packed {
    opcodeE           opcode;
    aluOpE            aluOp;
    logic [2:0]       funct3;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic             regWrite;
    logic             useImm;
    logic             usePc;
    logic             isBranch;
    logic             isJump;
    logic             isLoad;
    logic             isStore;
  } decodedOpT;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    logic             regWrite;
    logic [`XLEN-1:0] wdata;
  } retireT;

endpackage

`default_nettype wire

//--- fetch/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module fetchUnit (
  input  wire logic               clk,
  input  wire logic               rstN,
  output rvPkg::apbReqT           instApbReq,
  input  wire rvPkg::apbRspT      instApbRsp,
  input  wire logic               full,
  output logic                    push,
  output rvPkg::fetchPacketT      pushPacket,
  input  wire logic               redirect,
  input  wire logic [`XLEN-1:0]   redirectPc
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} stateE;

  stateE            state;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] reqAddr;
  logic             stale;
  logic             startFetch;
  logic             xferDone;

  // pc always points at the next word to request
  assign startFetch = (state == IDLE) && !full && !redirect;
  assign xferDone   = (state == ACCESS) && instApbRsp.pready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
      pc    <= `RESET_PC;
      stale <= 1'b0;
    end else begin
      case (state)
        IDLE:    if (startFetch) state <= SETUP;
        SETUP:   state <= ACCESS;
        // back to idle so full is seen after the push lands
        ACCESS:  if (instApbRsp.pready) state <= IDLE;
        default: state <= IDLE;
      endcase

      if (redirect) begin
        pc <= redirectPc;
      end else if (startFetch) begin
        pc <= pc + 4;
      end

      // transfer overtaken by a redirect finishes on the bus, data dropped
      if (xferDone) begin
        stale <= 1'b0;
      end else if (redirect && state != IDLE) begin
        stale <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startFetch) begin
      reqAddr <= pc;
    end
  end

  always_comb begin
    instApbReq.paddr   = reqAddr;
    instApbReq.pwdata  = '0;
    instApbReq.pwrite  = 1'b0;
    instApbReq.psel    = (state != IDLE);
    instApbReq.penable = (state == ACCESS);
  end

  assign push            = xferDone && !stale && !redirect;
  assign pushPacket.pc   = reqAddr;
  assign pushPacket.inst = instApbRsp.prdata;

endmodule

`default_nettype wire

//--- fetch/instBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module instBuffer #(
  parameter int DEPTH = `BUF_DEPTH
) (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               push,
  input  wire rvPkg::fetchPacketT pushPacket,
  output logic                    full,
  output logic                    headValid,
  output rvPkg::fetchPacketT      headPacket,
  input  wire logic               pop,
  input  wire logic               flush
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  rvPkg::fetchPacketT mem [DEPTH];
  logic [PW-1:0]      wrPtr;
  logic [PW-1:0]      rdPtr;
  logic [CW-1:0]      count;
  logic               doPush;
  logic               doPop;

  // pointer wrap for depths that are not a power of two
  function automatic logic [PW-1:0] nextPtr(input logic [PW-1:0] ptr);
    nextPtr = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign doPush     = push && !full;
  assign doPop      = pop && headValid;
  assign full       = (count == CW'(DEPTH));
  assign headValid  = (count != '0);
  assign headPacket = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop)  rdPtr <= nextPtr(rdPtr);
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushPacket;
    end
  end

endmodule

`default_nettype wire

//--- execute/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module decoder (
  input  wire logic [`XLEN-1:0] inst,
  output rvPkg::decodedOpT      decoded
);

  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;

  // alt is funct7 bit 5; sub only exists in the register form
  function automatic rvPkg::aluOpE aluSel(input logic [2:0] f3, input logic alt,
                                          input logic isReg);
    case (f3)
      3'b000:  aluSel = (alt && isReg) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
      3'b001:  aluSel = rvPkg::ALU_SLL;
      3'b010:  aluSel = rvPkg::ALU_SLT;
      3'b011:  aluSel = rvPkg::ALU_SLTU;
      3'b100:  aluSel = rvPkg::ALU_XOR;
      3'b101:  aluSel = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
      3'b110:  aluSel = rvPkg::ALU_OR;
      default: aluSel = rvPkg::ALU_AND;
    endcase
  endfunction

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    decoded        = '0;
    decoded.opcode = rvPkg::opcodeE'(inst[6:0]);
    decoded.aluOp  = rvPkg::ALU_ADD;
    decoded.funct3 = inst[14:12];
    decoded.rd     = inst[11:7];
    decoded.rs1    = inst[19:15];
    decoded.rs2    = inst[24:20];

    // anything not matched keeps all flags low and retires as a no-op
    case (decoded.opcode)
      rvPkg::OPC_LUI: begin
        decoded.imm      = immU;
        decoded.aluOp    = rvPkg::ALU_PASSB;
        decoded.useImm   = 1'b1;
        decoded.regWrite = 1'b1;
      end
      rvPkg::OPC_AUIPC: begin
        decoded.imm      = immU;
        decoded.usePc    = 1'b1;
        decoded.useImm   = 1'b1;
        decoded.regWrite = 1'b1;
      end
      rvPkg::OPC_JAL: begin
        decoded.imm      = immJ;
        decoded.isJump   = 1'b1;
        decoded.regWrite = 1'b1;
      end
      rvPkg::OPC_JALR: begin
        // alu forms rs1 + imm for the target
        decoded.imm      = immI;
        decoded.useImm   = 1'b1;
        decoded.isJump   = 1'b1;
        decoded.regWrite = 1'b1;
      end
      rvPkg::OPC_BRANCH: begin
        decoded.imm      = immB;
        decoded.isBranch = 1'b1;
      end
      rvPkg::OPC_LOAD: begin
        decoded.imm      = immI;
        decoded.useImm   = 1'b1;
        decoded.isLoad   = (inst[14:12] == 3'b010);
        decoded.regWrite = (inst[14:12] == 3'b010);
      end
      rvPkg::OPC_STORE: begin
        decoded.imm     = immS;
        decoded.useImm  = 1'b1;
        decoded.isStore = (inst[14:12] == 3'b010);
      end
      rvPkg::OPC_OPIMM: begin
        decoded.imm      = immI;
        decoded.aluOp    = aluSel(inst[14:12], inst[30], 1'b0);
        decoded.useImm   = 1'b1;
        decoded.regWrite = 1'b1;
      end
      rvPkg::OPC_OP: begin
        decoded.aluOp    = aluSel(inst[14:12], inst[30], 1'b1);
        decoded.regWrite = 1'b1;
      end
      default: begin
        decoded.imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module alu (
  input  wire logic [`XLEN-1:0] a,
  input  wire logic [`XLEN-1:0] b,
  input  wire rvPkg::aluOpE     aluOp,
  input  wire logic [2:0]       funct3,
  output logic [`XLEN-1:0]      result,
  output logic                  branchTaken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt    = ($signed(a) < $signed(b));
  assign ltu   = (a < b);

  always_comb begin
    case (aluOp)
      rvPkg::ALU_SUB:   result = a - b;
      rvPkg::ALU_SLL:   result = a << shamt;
      rvPkg::ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lt};
      rvPkg::ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, ltu};
      rvPkg::ALU_XOR:   result = a ^ b;
      rvPkg::ALU_SRL:   result = a >> shamt;
      rvPkg::ALU_SRA:   result = $signed(a) >>> shamt;
      rvPkg::ALU_OR:    result = a | b;
      rvPkg::ALU_AND:   result = a & b;
      rvPkg::ALU_PASSB: result = b;
      default:          result = a + b;
    endcase
  end

  // beq bne blt bge bltu bgeu, 010 and 011 never taken
  always_comb begin
    case (funct3)
      3'b000:  branchTaken = eq;
      3'b001:  branchTaken = !eq;
      3'b100:  branchTaken = lt;
      3'b101:  branchTaken = !lt;
      3'b110:  branchTaken = ltu;
      3'b111:  branchTaken = !ltu;
      default: branchTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- execute/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module execUnit (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               headValid,
  input  wire rvPkg::fetchPacketT headPacket,
  output logic                    pop,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  input  wire logic [`XLEN-1:0]   rdata1,
  input  wire logic [`XLEN-1:0]   rdata2,
  output logic                    wen,
  output logic [4:0]              rd,
  output logic [`XLEN-1:0]        wdata,
  output rvPkg::apbReqT           dataApbReq,
  input  wire rvPkg::apbRspT      dataApbRsp,
  output logic                    redirect,
  output logic [`XLEN-1:0]        redirectPc,
  output rvPkg::retireT           retire
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} stateE;

  rvPkg::decodedOpT op;
  stateE            memState;
  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] pcTarget;
  logic             branchTaken;
  logic             isMem;
  logic             memDone;
  logic             fire;

  decoder decoderInst (
    .inst    (headPacket.inst),
    .decoded (op)
  );

  assign opA = op.usePc  ? headPacket.pc : rdata1;
  assign opB = op.useImm ? op.imm        : rdata2;

  alu aluInst (
    .a           (opA),
    .b           (opB),
    .aluOp       (op.aluOp),
    .funct3      (op.funct3),
    .result      (aluResult),
    .branchTaken (branchTaken)
  );

  assign isMem    = op.isLoad || op.isStore;
  assign memDone  = (memState == ACCESS) && dataApbRsp.pready;
  // memory ops wait for the bus, everything else goes this cycle
  assign fire     = headValid && (isMem ? memDone : 1'b1);
  assign pcPlus4  = headPacket.pc + 4;
  assign pcTarget = headPacket.pc + op.imm;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memState <= IDLE;
    end else begin
      case (memState)
        IDLE:    if (headValid && isMem) memState <= SETUP;
        SETUP:   memState <= ACCESS;
        ACCESS:  if (dataApbRsp.pready) memState <= IDLE;
        default: memState <= IDLE;
      endcase
    end
  end

  // head is held during the transfer, so address and data stay stable
  always_comb begin
    dataApbReq.paddr   = aluResult;
    dataApbReq.pwdata  = rdata2;
    dataApbReq.pwrite  = op.isStore;
    dataApbReq.psel    = (memState != IDLE);
    dataApbReq.penable = (memState == ACCESS);
  end

  assign rs1   = op.rs1;
  assign rs2   = op.rs2;
  assign rd    = op.rd;
  assign pop   = fire;
  assign wen   = fire && op.regWrite;
  assign wdata = op.isLoad ? dataApbRsp.prdata : (op.isJump ? pcPlus4 : aluResult);

  assign redirect   = headValid && !isMem && (op.isJump || (op.isBranch && branchTaken));
  assign redirectPc = (op.opcode == rvPkg::OPC_JALR) ? {aluResult[`XLEN-1:1], 1'b0} : pcTarget;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= fire;
    end
    if (fire) begin
      retire.pc       <= headPacket.pc;
      retire.rd       <= op.rd;
      retire.regWrite <= op.regWrite;
      retire.wdata    <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module regFile (
  input  wire logic             clk,
  input  wire logic             rstN,
  input  wire logic [4:0]       rs1,
  input  wire logic [4:0]       rs2,
  output logic [`XLEN-1:0]      rdata1,
  output logic [`XLEN-1:0]      rdata2,
  input  wire logic             wen,
  input  wire logic [4:0]       rd,
  input  wire logic [`XLEN-1:0] wdata
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module rvCore (
  input  wire logic          clk,
  input  wire logic          rstN,
  output rvPkg::apbReqT      instApbReq,
  input  wire rvPkg::apbRspT instApbRsp,
  output rvPkg::apbReqT      dataApbReq,
  input  wire rvPkg::apbRspT dataApbRsp,
  output rvPkg::retireT      retire
);

  logic               full;
  logic               push;
  rvPkg::fetchPacketT pushPacket;
  logic               headValid;
  rvPkg::fetchPacketT headPacket;
  logic               pop;
  logic               redirect;
  logic [`XLEN-1:0]   redirectPc;
  logic [4:0]         rs1;
  logic [4:0]         rs2;
  logic [`XLEN-1:0]   rdata1;
  logic [`XLEN-1:0]   rdata2;
  logic               wen;
  logic [4:0]         rd;
  logic [`XLEN-1:0]   wdata;

  fetchUnit fetchInst (
    .clk        (clk),
    .rstN       (rstN),
    .instApbReq (instApbReq),
    .instApbRsp (instApbRsp),
    .full       (full),
    .push       (push),
    .pushPacket (pushPacket),
    .redirect   (redirect),
    .redirectPc (redirectPc)
  );

  // redirect doubles as the buffer flush
  instBuffer #(.DEPTH(`BUF_DEPTH)) bufferInst (
    .clk        (clk),
    .rstN       (rstN),
    .push       (push),
    .pushPacket (pushPacket),
    .full       (full),
    .headValid  (headValid),
    .headPacket (headPacket),
    .pop        (pop),
    .flush      (redirect)
  );

  execUnit execInst (
    .clk        (clk),
    .rstN       (rstN),
    .headValid  (headValid),
    .headPacket (headPacket),
    .pop        (pop),
    .rs1        (rs1),
    .rs2        (rs2),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .wen        (wen),
    .rd         (rd),
    .wdata      (wdata),
    .dataApbReq (dataApbReq),
    .dataApbRsp (dataApbRsp),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .retire     (retire)
  );

  regFile regFileInst (
    .clk    (clk),
    .rstN   (rstN),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (wen),
    .rd     (rd),
    .wdata  (wdata)
  );

endmodule

`default_nettype wire

//--- testbench/tbRefModel.svh
`ifndef TBREFMODEL_SVH
`define TBREFMODEL_SVH

// architectural state of the reference model
logic [31:0] refRegs [`NUM_REGS];
logic [31:0] refMem [DATA_WORDS];
logic [31:0] refPc;
logic [31:0] rngState;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] randBits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    rngState = lfsrNext(rngState);
    r = {r[30:0], rngState[31]};
  end
  return r;
endfunction

// initial data memory contents, every word differs
function automatic logic [31:0] fillWord(input int i);
  return (32'(i) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
endfunction

function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

// alt selects sub or sra
function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

task automatic refReset();
  refPc = `RESET_PC;
  for (int i = 0; i < `NUM_REGS; i++) begin
    refRegs[i] = '0;
  end
  for (int i = 0; i < DATA_WORDS; i++) begin
    refMem[i] = fillWord(i);
  end
endtask

// executes the instruction at refPc and reports what it retires
task automatic refStep(output logic [31:0] pc, output logic [4:0] rd, output logic wr,
                       output logic [31:0] wd, output logic st, output logic [31:0] sa,
                       output logic [31:0] sd);
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immU;
  logic [31:0] immJ;
  logic [31:0] nextPc;
  w      = instWord(refPc);
  a      = refRegs[w[19:15]];
  b      = refRegs[w[24:20]];
  immI   = {{20{w[31]}}, w[31:20]};
  immS   = {{20{w[31]}}, w[31:25], w[11:7]};
  immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  immU   = {w[31:12], 12'h000};
  immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  pc     = refPc;
  rd     = w[11:7];
  wr     = 1'b0;
  wd     = '0;
  st     = 1'b0;
  sa     = '0;
  sd     = '0;
  nextPc = refPc + 32'd4;
  case (w[6:0])
    7'b0110111: begin
      wr = 1'b1;
      wd = immU;
    end
    7'b0010111: begin
      wr = 1'b1;
      wd = refPc + immU;
    end
    7'b1101111: begin
      wr     = 1'b1;
      wd     = refPc + 32'd4;
      nextPc = refPc + immJ;
    end
    7'b1100111: begin
      wr     = 1'b1;
      wd     = refPc + 32'd4;
      nextPc = (a + immI) & ~32'd1;
    end
    7'b1100011: begin
      if (branchCond(w[14:12], a, b)) begin
        nextPc = refPc + immB;
      end
    end
    7'b0000011: begin
      wr = 1'b1;
      sa = a + immI;
      wd = refMem[sa[9:2]];
    end
    7'b0100011: begin
      st = 1'b1;
      sa = a + immS;
      sd = b;
      refMem[sa[9:2]] = b;
    end
    7'b0010011: begin
      wr = 1'b1;
      wd = aluCalc(w[14:12], w[30] && (w[14:12] == 3'b101), a, immI);
    end
    7'b0110011: begin
      wr = 1'b1;
      wd = aluCalc(w[14:12], w[30], a, b);
    end
    default: begin
      wr = 1'b0;
    end
  endcase
  // x0 stays zero
  if (wr && rd != 5'd0) begin
    refRegs[rd] = wd;
  end
  refPc = nextPc;
endtask

`endif

//--- testbench/tbRvCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defines.svh"

module tbRvCore;

  localparam int          CLK_PERIOD      = 8;
  localparam int          NUM_INSTS       = 256;
  localparam int          DATA_WORDS      = 256;
  localparam int          WATCHDOG_CYCLES = NUM_INSTS * 20 + 500;
  localparam logic [31:0] PROG_BYTES      = 32'(NUM_INSTS * 4);
  localparam logic [31:0] SELF_LOOP       = 32'h0000_006F;
  localparam logic [31:0] SEED            = 32'h5982_1678;

  logic          clk;
  logic          rstN;
  rvPkg::apbReqT instApbReq;
  rvPkg::apbRspT instApbRsp;
  rvPkg::apbReqT dataApbReq;
  rvPkg::apbRspT dataApbRsp;
  rvPkg::retireT retire;

  logic [31:0]   progMem [NUM_INSTS];
  logic [31:0]   dataMem [DATA_WORDS];
  logic [63:0]   storeQ [$];
  rvPkg::apbReqT heldReq [2];
  logic          inAccess [2];
  int            waitCnt [2];
  logic          nextReady [2];
  logic [31:0]   nextRdata [2];
  logic          firstFetch;
  logic          done;

  // words past the program hold the self-loop
  function automatic logic [31:0] instWord(input logic [31:0] addr);
    logic [31:0] rel;
    rel = addr - `RESET_PC;
    if (rel < PROG_BYTES) begin
      return progMem[rel[9:2]];
    end
    return SELF_LOOP;
  endfunction

  `include "tbRefModel.svh"

  rvCore UUT (
    .clk        (clk),
    .rstN       (rstN),
    .instApbReq (instApbReq),
    .instApbRsp (instApbRsp),
    .dataApbReq (dataApbReq),
    .dataApbRsp (dataApbRsp),
    .retire     (retire)
  );

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
    else failNow($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  function automatic logic [31:0] genInst(input logic [31:0] pc);
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [19:0] upper;
    logic [11:0] imm;
    logic [11:0] memOff;
    logic [31:0] off;
    logic [31:0] target;
    logic        alt;
    kind   = 4'(randBits(4));
    rd     = 5'(randBits(5));
    rs1    = 5'(randBits(5));
    rs2    = 5'(randBits(5));
    f3     = 3'(randBits(3));
    upper  = 20'(randBits(20));
    imm    = 12'(randBits(12));
    memOff = {2'b00, imm[7:0], 2'b00};
    // forward by 4 to 32 bytes
    off    = (randBits(3) + 32'd1) << 2;
    target = pc + off;
    alt    = imm[11] && (f3 == 3'b000 || f3 == 3'b101);
    case (kind)
      4'd0: return {upper, rd, 7'b0110111};
      4'd1: return {upper, rd, 7'b0010111};
      4'd2: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
      4'd3: return {target[11:0], 5'd0, 3'b000, rd, 7'b1100111};
      4'd4, 4'd5: begin
        // 010 and 011 are not branches
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
      end
      4'd6: return {memOff, 5'd0, 3'b010, rd, 7'b0000011};
      4'd7: return {memOff[11:5], rs2, 5'd0, 3'b010, memOff[4:0], 7'b0100011};
      4'd8, 4'd9, 4'd10, 4'd11: begin
        if (f3 == 3'b001) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, imm[10], 5'b0, imm[4:0]};
        end
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      default: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endcase
  endfunction

  // APB slave for port 0 (instruction memory) or port 1 (data memory)
  task automatic serveApb(input int port, input rvPkg::apbReqT req, input logic ready);
    string name;
    name = (port == 0) ? "instApbReq" : "dataApbReq";
    assert (req.psel || !req.penable)
    else failNow($sformatf("penable high without psel on %s", name));
    if (req.psel && !req.penable) begin
      assert (!inAccess[port])
      else failNow($sformatf("setup phase on %s while a transfer is open", name));
      heldReq[port]  = req;
      inAccess[port] = 1'b1;
      waitCnt[port]  = int'(randBits(2));
      nextReady[port] = (waitCnt[port] == 0);
      if (port == 0) begin
        checkValue("instApbReq.pwrite", 32'(req.pwrite), 32'd0);
        if (firstFetch) begin
          checkValue("instApbReq.paddr", req.paddr, `RESET_PC);
          firstFetch = 1'b0;
        end
        nextRdata[0] = instWord(req.paddr);
      end else begin
        nextRdata[1] = req.pwrite ? 32'd0 : dataMem[req.paddr[9:2]];
      end
    end else if (req.psel && req.penable) begin
      assert (inAccess[port])
      else failNow($sformatf("access phase on %s without a setup phase", name));
      checkValue({name, ".paddr"}, req.paddr, heldReq[port].paddr);
      checkValue({name, ".pwdata"}, req.pwdata, heldReq[port].pwdata);
      checkValue({name, ".pwrite"}, 32'(req.pwrite), 32'(heldReq[port].pwrite));
      if (ready) begin
        inAccess[port]  = 1'b0;
        nextReady[port] = 1'b0;
        if (port == 1 && req.pwrite) begin
          dataMem[req.paddr[9:2]] = req.pwdata;
          storeQ.push_back({req.paddr, req.pwdata});
        end
      end else begin
        waitCnt[port]   = waitCnt[port] - 1;
        nextReady[port] = (waitCnt[port] == 0);
      end
    end else begin
      assert (!inAccess[port])
      else failNow($sformatf("psel on %s dropped before pready", name));
      nextReady[port] = 1'b0;
    end
  endtask

  task automatic checkQuietBus();
    checkValue("{inst psel, inst penable, data psel, data penable, retire.valid}",
               32'({instApbReq.psel, instApbReq.penable, dataApbReq.psel,
                    dataApbReq.penable, retire.valid}), 32'd0);
  endtask

  task automatic checkRetire(output logic last);
    logic [31:0] expPc;
    logic [4:0]  expRd;
    logic        expWrite;
    logic [31:0] expWdata;
    logic        expStore;
    logic [31:0] stAddr;
    logic [31:0] stData;
    logic [63:0] seen;
    refStep(expPc, expRd, expWrite, expWdata, expStore, stAddr, stData);
    checkValue("retire.pc", retire.pc, expPc);
    checkValue("retire.regWrite", 32'(retire.regWrite), 32'(expWrite));
    if (expWrite) begin
      checkValue("retire.rd", 32'(retire.rd), 32'(expRd));
      checkValue("retire.wdata", retire.wdata, expWdata);
    end
    if (expStore) begin
      assert (storeQ.size() > 0)
      else failNow("a store retired without a write transfer on the data port");
      seen = storeQ.pop_front();
      checkValue("dataApbReq.paddr", seen[63:32], stAddr);
      checkValue("dataApbReq.pwdata", seen[31:0], stData);
    end
    last = (expPc - `RESET_PC) >= PROG_BYTES;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // both APB slaves share one process and one random sequence
  initial begin
    instApbRsp = '0;
    dataApbRsp = '0;
    firstFetch = 1'b1;
    for (int p = 0; p < 2; p++) begin
      inAccess[p]  = 1'b0;
      waitCnt[p]   = 0;
      nextReady[p] = 1'b0;
      nextRdata[p] = '0;
    end
    forever begin
      @(negedge clk);
      if (rstN) begin
        serveApb(0, instApbReq, instApbRsp.pready);
        serveApb(1, dataApbReq, dataApbRsp.pready);
      end
      @(posedge clk);
      #1;
      instApbRsp.pready = nextReady[0];
      instApbRsp.prdata = nextRdata[0];
      dataApbRsp.pready = nextReady[1];
      dataApbRsp.prdata = nextRdata[1];
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    failNow("timeout: the self-loop address never retired");
  end

  initial begin
    rstN     = 1'b0;
    done     = 1'b0;
    rngState = SEED;
    refReset();
    for (int i = 0; i < NUM_INSTS; i++) begin
      progMem[i] = genInst(`RESET_PC + 32'(i) * 32'd4);
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      dataMem[i] = fillWord(i);
    end

    // five reset cycles with outputs checked after the first edge
    @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      checkQuietBus();
      @(posedge clk);
    end
    #1;
    rstN = 1'b1;
    @(negedge clk);
    checkQuietBus();

    while (!done) begin
      @(negedge clk);
      if (retire.valid) begin
        checkRetire(done);
      end
    end
    assert (storeQ.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      failNow("a write transfer on the data port never retired as a store");
    end
  end

endmodule

`default_nettype wire

//--- rvCore.f
+incdir+common
+incdir+testbench
common/rvPkg.sv
fetch/fetchUnit.sv
fetch/instBuffer.sv
execute/decoder.sv
execute/alu.sv
execute/execUnit.sv
logic/regFile.sv
logic/rvCore.sv
testbench/tbRvCore.sv

//--- run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tbRvCore \
  -f rvCore.f \
  -o simRvCore
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/simRvCore
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: simulation failed with status $status"
  exit "$status"
fi

echo "run.sh: simulation finished"
exit 0
